/* Bender.yml */
package:
  name: edge_data_read

sources:
  - files:
      - rtl/graph_cu_pkg.sv
      - rtl/sync_fifo.sv
      - rtl/edge_data_read_command_control.sv
      - rtl/edge_data_read_return.sv
      - rtl/edge_data_read_unit.sv
  - target: test
    files:
      - testbench/clock_gen.sv
      - testbench/edge_data_read_tb.sv

/* all.f */
rtl/graph_cu_pkg.sv
rtl/sync_fifo.sv
rtl/edge_data_read_command_control.sv
rtl/edge_data_read_return.sv
rtl/edge_data_read_unit.sv
testbench/clock_gen.sv
testbench/edge_data_read_tb.sv

/* rtl/edge_data_read_command_control.sv */
// Edge data read command control
`timescale 1ns/100ps
`default_nettype none

module edge_data_read_command_control (
	input  logic                                        clock,
	input  logic                                        rstn,
	input  logic                                        enabled_in,
	input  logic [63:0]                                 cu_configure,
	input  logic                                        wed_valid,
	input  logic [graph_cu_pkg::address_width-1:0]      wed_property_base,
	input  logic                                        edge_job_valid,
	input  logic [graph_cu_pkg::vertex_index_width-1:0] edge_job_dest,
	output logic                                        edge_request,
	input  logic                                        read_buffer_alfull,
	input  logic                                        read_command_bus_grant,
	output logic                                        read_command_bus_request,
	output logic                                        read_command_valid,
	output logic [graph_cu_pkg::address_width-1:0]      read_command_address,
	output logic [graph_cu_pkg::command_size_width-1:0] read_command_size,
	output logic [graph_cu_pkg::command_code_width-1:0] read_command_code,
	output logic [graph_cu_pkg::abt_width-1:0]          read_command_abt,
	output logic [graph_cu_pkg::line_offset_width-1:0]  read_command_line_offset,
	output logic [graph_cu_pkg::vertex_index_width-1:0] read_command_dest
);

	import graph_cu_pkg::*;

	localparam int cmd_width = address_width + command_code_width + abt_width
		+ line_offset_width + vertex_index_width;

	logic [63:0] cfg_reg;
	logic [63:0] cfg_latched;
	logic enabled_cmd;
	logic [address_width-1:0] property_base;

	logic job_valid_in;
	logic [vertex_index_width-1:0] job_dest_in;
	logic job_alfull;
	logic job_empty;
	logic job_pop;
	logic job_valid;
	logic [vertex_index_width-1:0] job_dest;

	logic [address_width-1:0] byte_offset;
	logic cmd_valid;
	logic [address_width-1:0] cmd_address;
	logic [command_code_width-1:0] cmd_code;
	logic [abt_width-1:0] cmd_abt;
	logic [line_offset_width-1:0] cmd_offset;
	logic [vertex_index_width-1:0] cmd_dest;

	logic cmd_alfull;
	logic cmd_empty;
	logic cmd_pop;
	logic grant_reg;

	////////////////////////////////////////////////////////////
	// Enable and configuration
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cfg_reg <= '0;
			cfg_latched <= '0;
			enabled_cmd <= 1'b0;
		end else begin
			cfg_reg <= cu_configure;
			// A zero word leaves the capture in place
			if (enabled_in && (|cfg_reg))
				cfg_latched <= cfg_reg;
			enabled_cmd <= enabled_in && (|cfg_latched);
		end
	end

	always_ff @(posedge clock) begin
		if (enabled_in && wed_valid)
			property_base <= wed_property_base;
		job_dest_in <= edge_job_dest;
	end

	////////////////////////////////////////////////////////////
	// Edge jobs
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_valid_in <= 1'b0;
			edge_request <= 1'b0;
		end else begin
			job_valid_in <= enabled_in && edge_job_valid;
			edge_request <= enabled_in && !job_alfull;
		end
	end

	// Jobs wait here until issue is allowed
	assign job_pop = enabled_cmd && !job_empty && !cmd_alfull;

	sync_fifo #(
		.WIDTH(vertex_index_width),
		.DEPTH(edge_job_buffer_depth)
	) job_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_valid_in),
		.data_in (job_dest_in),
		.full    (),
		.alfull  (job_alfull),
		.pop     (job_pop),
		.valid   (job_valid),
		.data_out(job_dest),
		.empty   (job_empty)
	);

	////////////////////////////////////////////////////////////
	// Command former
	////////////////////////////////////////////////////////////

	assign byte_offset = address_width'(job_dest) << $clog2(data_size_read);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			cmd_valid <= 1'b0;
		else
			cmd_valid <= job_valid;
	end

	always_ff @(posedge clock) begin
		cmd_address <= (property_base + byte_offset) & address_align_mask;
		cmd_offset <= job_dest[line_offset_width-1:0];
		cmd_dest <= job_dest;
		cmd_abt <= map_cache_abt(cfg_latched[cfg_abt_lsb +: 3]);
		if (cfg_latched[cfg_cmd_shared_bit])
			cmd_code <= cmd_read_cl_s;
		else
			cmd_code <= cmd_read_cl_na;
	end

	////////////////////////////////////////////////////////////
	// Command buffer and bus side
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_reg <= 1'b0;
			read_command_bus_request <= 1'b0;
		end else begin
			grant_reg <= enabled_cmd && read_command_bus_grant;
			read_command_bus_request <= enabled_cmd && !cmd_empty && !read_buffer_alfull;
		end
	end

	// A late grant on an empty buffer is dropped
	assign cmd_pop = grant_reg && !read_buffer_alfull && !cmd_empty;

	sync_fifo #(
		.WIDTH(cmd_width),
		.DEPTH(edge_job_buffer_depth)
	) command_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (cmd_valid),
		.data_in ({cmd_address, cmd_code, cmd_abt, cmd_offset, cmd_dest}),
		.full    (),
		.alfull  (cmd_alfull),
		.pop     (cmd_pop),
		.valid   (read_command_valid),
		.data_out({read_command_address, read_command_code, read_command_abt,
			read_command_line_offset, read_command_dest}),
		.empty   (cmd_empty)
	);

	assign read_command_size = command_size_width'(cacheline_bytes);

	// Issue only from a cycle where the unit was enabled
	valid_only_when_enabled: assert property (
		@(posedge clock) disable iff (!rstn)
		$rose(read_command_valid) |-> $past(enabled_cmd)
	);

endmodule

`default_nettype wire

/* rtl/edge_data_read_return.sv */
// Edge data read return path
`timescale 1ns/100ps
`default_nettype none

module edge_data_read_return (
	input  logic                                        clock,
	input  logic                                        rstn,
	input  logic                                        enabled,
	input  logic                                        read_response_valid,
	input  logic [graph_cu_pkg::line_offset_width-1:0]  read_response_line_offset,
	input  logic [graph_cu_pkg::vertex_index_width-1:0] read_response_dest,
	input  logic [graph_cu_pkg::cacheline_bits-1:0]     read_response_data,
	input  logic                                        edge_data_request,
	output logic                                        edge_data_valid,
	output logic [graph_cu_pkg::vertex_index_width-1:0] edge_data_dest,
	output logic [graph_cu_pkg::property_width-1:0]     edge_data_value,
	output logic                                        data_buffer_full,
	output logic                                        data_buffer_alfull,
	output logic                                        data_buffer_empty
);

	import graph_cu_pkg::*;

	logic resp_valid;
	logic [line_offset_width-1:0] resp_offset;
	logic [vertex_index_width-1:0] resp_dest;
	logic [cacheline_bits-1:0] resp_data;

	logic word_valid;
	logic [vertex_index_width-1:0] word_dest;
	logic [property_width-1:0] word_value;

	logic request_reg;
	logic data_pop;

	////////////////////////////////////////////////////////////
	// Response capture and word select
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			resp_valid <= 1'b0;
			word_valid <= 1'b0;
			request_reg <= 1'b0;
		end else begin
			resp_valid <= enabled && read_response_valid;
			word_valid <= resp_valid;
			request_reg <= enabled && edge_data_request;
		end
	end

	always_ff @(posedge clock) begin
		resp_offset <= read_response_line_offset;
		resp_dest <= read_response_dest;
		resp_data <= read_response_data;
		// Word 0 sits in the low bits of the line
		word_value <= resp_data[resp_offset * property_width +: property_width];
		word_dest <= resp_dest;
	end

	////////////////////////////////////////////////////////////
	// Data buffer toward the consumer
	////////////////////////////////////////////////////////////

	assign data_pop = request_reg && !data_buffer_empty;

	sync_fifo #(
		.WIDTH(vertex_index_width + property_width),
		.DEPTH(edge_job_buffer_depth)
	) data_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (word_valid),
		.data_in ({word_dest, word_value}),
		.full    (data_buffer_full),
		.alfull  (data_buffer_alfull),
		.pop     (data_pop),
		.valid   (edge_data_valid),
		.data_out({edge_data_dest, edge_data_value}),
		.empty   (data_buffer_empty)
	);

	// Every word handed out carries a known dest and value
	data_known_when_valid: assert property (
		@(posedge clock) disable iff (!rstn)
		edge_data_valid |-> !$isunknown({edge_data_dest, edge_data_value})
	);

endmodule

`default_nettype wire

/* rtl/edge_data_read_unit.sv */
// Edge data read unit
`timescale 1ns/100ps
`default_nettype none

module edge_data_read_unit (
	input  logic                                        clock,
	input  logic                                        rstn,
	input  logic                                        enabled_in,
	input  logic [63:0]                                 cu_configure,
	input  logic                                        wed_valid,
	input  logic [graph_cu_pkg::address_width-1:0]      wed_property_base,
	input  logic                                        edge_job_valid,
	input  logic [graph_cu_pkg::vertex_index_width-1:0] edge_job_dest,
	output logic                                        edge_request,
	input  logic                                        read_buffer_alfull,
	input  logic                                        read_command_bus_grant,
	output logic                                        read_command_bus_request,
	output logic                                        read_command_valid,
	output logic [graph_cu_pkg::address_width-1:0]      read_command_address,
	output logic [graph_cu_pkg::command_size_width-1:0] read_command_size,
	output logic [graph_cu_pkg::command_code_width-1:0] read_command_code,
	output logic [graph_cu_pkg::abt_width-1:0]          read_command_abt,
	output logic [graph_cu_pkg::line_offset_width-1:0]  read_command_line_offset,
	output logic [graph_cu_pkg::vertex_index_width-1:0] read_command_dest,
	input  logic                                        read_response_valid,
	input  logic [graph_cu_pkg::line_offset_width-1:0]  read_response_line_offset,
	input  logic [graph_cu_pkg::vertex_index_width-1:0] read_response_dest,
	input  logic [graph_cu_pkg::cacheline_bits-1:0]     read_response_data,
	input  logic                                        edge_data_request,
	output logic                                        edge_data_valid,
	output logic [graph_cu_pkg::vertex_index_width-1:0] edge_data_dest,
	output logic [graph_cu_pkg::property_width-1:0]     edge_data_value,
	output logic                                        data_buffer_full,
	output logic                                        data_buffer_alfull,
	output logic                                        data_buffer_empty
);

	logic enabled;

	// One enable for both halves so they stop together
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			enabled <= 1'b0;
		else
			enabled <= enabled_in;
	end

	edge_data_read_command_control command_control0 (
		.enabled_in(enabled),
		.*
	);

	edge_data_read_return return0 (
		.*
	);

endmodule

`default_nettype wire

/* rtl/graph_cu_pkg.sv */
// Graph compute unit definitions
`default_nettype none

package graph_cu_pkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////

	// Bytes per vertex property word
	localparam int data_size_read = 4;
	localparam int property_width = data_size_read * 8;

	localparam int cacheline_bytes = 128;
	localparam int cacheline_bits = cacheline_bytes * 8;
	localparam int address_width = 64;
	localparam int vertex_index_width = 32;
	localparam int line_offset_width = 5;

	// Clears byte address bits below the cache line
	localparam logic [address_width-1:0] address_align_mask = 64'hFFFF_FFFF_FFFF_FF80;

	// All FIFOs in the unit share this depth
	localparam int edge_job_buffer_depth = 16;
	localparam int fifo_alfull_margin = 4;

	////////////////////////////////////////////////////////////
	// Command encodings
	////////////////////////////////////////////////////////////

	localparam int command_code_width = 13;
	localparam int command_size_width = 12;
	localparam int abt_width = 3;

	localparam logic [command_code_width-1:0] cmd_read_cl_s = 13'h0A50;
	localparam logic [command_code_width-1:0] cmd_read_cl_na = 13'h0A00;

	// Translation ordering codes
	localparam logic [abt_width-1:0] abt_strict = 3'b000;
	localparam logic [abt_width-1:0] abt_abort = 3'b001;
	localparam logic [abt_width-1:0] abt_page = 3'b010;
	localparam logic [abt_width-1:0] abt_pref = 3'b011;
	localparam logic [abt_width-1:0] abt_spec = 3'b111;

	// Field positions in the configuration word
	localparam int cfg_abt_lsb = 51;
	localparam int cfg_cmd_shared_bit = 50;

	// Cache behaviour field to translation ordering
	function automatic logic [abt_width-1:0] map_cache_abt(input logic [2:0] cabt);
		logic [abt_width-1:0] abt;
		case (cabt)
			3'b000: abt = abt_strict;
			3'b001: abt = abt_abort;
			3'b010: abt = abt_page;
			3'b011: abt = abt_pref;
			3'b100: abt = abt_spec;
			3'b101: abt = abt_page;
			3'b110: abt = abt_pref;
			3'b111: abt = abt_spec;
			default: abt = abt_strict;
		endcase
		return abt;
	endfunction

endpackage

`default_nettype wire

/* rtl/sync_fifo.sv */
// Synchronous FIFO
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = graph_cu_pkg::edge_job_buffer_depth
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	output logic             full,
	output logic             alfull,
	input  logic             pop,
	output logic             valid,
	output logic [WIDTH-1:0] data_out,
	output logic             empty
);

	import graph_cu_pkg::*;

	localparam int ptr_width = $clog2(DEPTH);
	localparam int count_width = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic [count_width-1:0] count;

	assign full = (count == count_width'(DEPTH));
	assign empty = (count == '0);
	// Rises with margin entries still free
	assign alfull = ((count_width'(DEPTH) - count) <= count_width'(fifo_alfull_margin));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			valid <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			valid <= pop;
		end
	end

	// Storage and read word
	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= data_in;
		if (pop)
			data_out <= mem[rd_ptr];
	end

	no_push_when_full: assert property (
		@(posedge clock) disable iff (!rstn) push |-> !full
	);

	no_pop_when_empty: assert property (
		@(posedge clock) disable iff (!rstn) pop |-> !empty
	);

endmodule

`default_nettype wire

/* testbench/clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Reset held for four rising edges
	initial begin
		rstn = 1'b0;
		repeat (4) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

`default_nettype wire

/* testbench/edge_data_read_tb.sv */
// Edge data read unit testbench
`timescale 1ns/100ps
`default_nettype none

module edge_data_read_tb;

	logic clock;
	logic rstn;
	logic enabled_in;
	logic [63:0] cu_configure;
	logic wed_valid;
	logic [63:0] wed_property_base;
	logic edge_job_valid;
	logic [31:0] edge_job_dest;
	logic edge_request;
	logic read_buffer_alfull;
	logic read_command_bus_grant;
	logic read_command_bus_request;
	logic read_command_valid;
	logic [63:0] read_command_address;
	logic [11:0] read_command_size;
	logic [12:0] read_command_code;
	logic [2:0] read_command_abt;
	logic [4:0] read_command_line_offset;
	logic [31:0] read_command_dest;
	logic read_response_valid;
	logic [4:0] read_response_line_offset;
	logic [31:0] read_response_dest;
	logic [1023:0] read_response_data;
	logic edge_data_request;
	logic edge_data_valid;
	logic [31:0] edge_data_dest;
	logic [31:0] edge_data_value;
	logic data_buffer_full;
	logic data_buffer_alfull;
	logic data_buffer_empty;

	// Shared read, behaviour field 3'b100
	localparam logic [63:0] cfg_word = 64'h0024_0000_0000_00A1;
	localparam logic [63:0] base_addr = 64'h0000_0012_3456_7800;

	logic [31:0] lfsr_state = 32'h915674cd;
	logic [31:0] prop [256];
	logic [31:0] cmd_expect_q [$];
	logic [31:0] data_expect_q [$];
	logic [63:0] mem_addr_q [$];
	logic [4:0] mem_offset_q [$];
	logic [31:0] mem_dest_q [$];
	int issued = 0;
	int expected_total = 0;
	logic quiet = 1'b1;
	logic quiet_strict = 1'b1;
	logic hold_grants = 1'b0;
	logic force_alfull = 1'b0;
	logic random_alfull = 1'b0;

	clock_gen clock_gen0 (.clock(clock), .rstn(rstn));

	edge_data_read_unit dut0 (.*);

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			else
				lfsr_state = lfsr_state >> 1;
		end
		return r;
	endfunction

	// Expected command fields for one job
	function automatic void expected_command(input logic [31:0] dest, output logic [63:0] addr,
		output logic [4:0] offset, output logic [12:0] code, output logic [2:0] abt);
		logic [2:0] field;
		field = cfg_word[53:51];
		addr = (base_addr + {dest, 2'b00}) & ~64'h7F;
		offset = dest[4:0];
		code = cfg_word[50] ? graph_cu_pkg::cmd_read_cl_s : graph_cu_pkg::cmd_read_cl_na;
		case (field)
			3'd0: abt = 3'b000;
			3'd1: abt = 3'b001;
			3'd2, 3'd5: abt = 3'b010;
			3'd3, 3'd6: abt = 3'b011;
			default: abt = 3'b111;
		endcase
	endfunction

	task automatic report_error(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp) else begin
			report_error($sformatf("error %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic send_job(input logic [31:0] dest, input bit expected);
		@(posedge clock);
		edge_job_valid <= 1'b1;
		edge_job_dest <= dest;
		if (expected) begin
			cmd_expect_q.push_back(dest);
			expected_total++;
		end
		@(posedge clock);
		edge_job_valid <= 1'b0;
	endtask

	task automatic wait_edge_request();
		int t = 0;
		@(negedge clock);
		while (!edge_request) begin
			t++;
			if (t > 500)
				report_error("timeout waiting for edge_request");
			@(negedge clock);
		end
	endtask

	task automatic wait_drained(input int limit);
		int t = 0;
		@(negedge clock);
		while (cmd_expect_q.size() > 0 || data_expect_q.size() > 0 || mem_dest_q.size() > 0) begin
			t++;
			if (t > limit)
				report_error("timeout waiting for all jobs to return data");
			@(negedge clock);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Bus arbiter and host models
	////////////////////////////////////////////////////////////

	initial begin
		int gap;
		forever begin
			@(negedge clock);
			if (!hold_grants && read_command_bus_request) begin
				gap = rand_bits(2);
				repeat (gap) @(posedge clock);
				@(posedge clock);
				read_command_bus_grant <= 1'b1;
				@(posedge clock);
				read_command_bus_grant <= 1'b0;
			end
		end
	end

	always @(posedge clock)
		read_buffer_alfull <= force_alfull || (random_alfull && rand_bits(3) == 0);

	// Memory returns the addressed line after a random delay
	initial begin
		logic [63:0] addr;
		int idx;
		int delay;
		forever begin
			@(negedge clock);
			if (mem_dest_q.size() > 0 && !data_buffer_alfull) begin
				addr = mem_addr_q.pop_front();
				idx = int'((addr - base_addr) >> 2);
				delay = rand_bits(2);
				repeat (delay) @(posedge clock);
				@(posedge clock);
				read_response_valid <= 1'b1;
				read_response_line_offset <= mem_offset_q.pop_front();
				read_response_dest <= mem_dest_q.pop_front();
				for (int i = 0; i < 32; i++)
					read_response_data[i*32 +: 32] <= prop[(idx + i) & 255];
				@(posedge clock);
				read_response_valid <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Compare processes
	////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		logic [31:0] dest;
		logic [63:0] addr;
		logic [4:0] offset;
		logic [12:0] code;
		logic [2:0] abt;
		if (rstn && quiet) begin
			check_value("read_command_valid", read_command_valid, 0);
			check_value("edge_data_valid", edge_data_valid, 0);
			check_value("data_buffer_empty", data_buffer_empty, 1);
			if (quiet_strict) begin
				check_value("edge_request", edge_request, 0);
				check_value("read_command_bus_request", read_command_bus_request, 0);
				check_value("data_buffer_full", data_buffer_full, 0);
				check_value("data_buffer_alfull", data_buffer_alfull, 0);
			end
		end
		if (rstn && read_command_valid) begin
			assert (cmd_expect_q.size() > 0) else begin
				report_error("a read command was issued with no job outstanding");
			end
			dest = cmd_expect_q.pop_front();
			expected_command(dest, addr, offset, code, abt);
			issued++;
			check_value("read_command_dest", read_command_dest, dest);
			check_value("read_command_address", read_command_address, addr);
			check_value("read_command_line_offset", read_command_line_offset, offset);
			check_value("read_command_size", read_command_size, 128);
			check_value("read_command_code", read_command_code, code);
			check_value("read_command_abt", read_command_abt, abt);
			mem_addr_q.push_back(read_command_address);
			mem_offset_q.push_back(read_command_line_offset);
			mem_dest_q.push_back(read_command_dest);
			data_expect_q.push_back(dest);
		end
	end

	// Consumer pulls one word at a time and checks its timing
	initial begin
		logic [31:0] dest;
		int gap;
		forever begin
			@(negedge clock);
			if (rstn && !data_buffer_empty) begin
				gap = rand_bits(2);
				repeat (gap) @(negedge clock);
				@(posedge clock);
				edge_data_request <= 1'b1;
				@(posedge clock);
				edge_data_request <= 1'b0;
				@(negedge clock);
				check_value("edge_data_valid", edge_data_valid, 0);
				@(negedge clock);
				check_value("edge_data_valid", edge_data_valid, 1);
				assert (data_expect_q.size() > 0) else begin
					report_error("edge data arrived with no command outstanding");
				end
				dest = data_expect_q.pop_front();
				check_value("edge_data_dest", edge_data_dest, dest);
				check_value("edge_data_value", edge_data_value, prop[dest[7:0]]);
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int t;
		enabled_in = 1'b0;
		cu_configure = '0;
		wed_valid = 1'b0;
		wed_property_base = '0;
		edge_job_valid = 1'b0;
		edge_job_dest = '0;
		read_buffer_alfull = 1'b0;
		read_command_bus_grant = 1'b0;
		read_response_valid = 1'b0;
		read_response_line_offset = '0;
		read_response_dest = '0;
		read_response_data = '0;
		edge_data_request = 1'b0;
		for (int i = 0; i < 256; i++)
			prop[i] = rand_bits(32);

		t = 0;
		while (!rstn) begin
			t++;
			if (t > 20)
				report_error("reset never released");
			@(posedge clock);
		end

		// Disabled unit ignores jobs
		for (int i = 0; i < 3; i++)
			send_job(rand_bits(8), 0);
		repeat (20) @(posedge clock);
		quiet_strict <= 1'b0;

		// Enabled with zero configuration holds jobs back
		enabled_in <= 1'b1;
		repeat (3) @(posedge clock);
		wed_valid <= 1'b1;
		wed_property_base <= base_addr;
		@(posedge clock);
		wed_valid <= 1'b0;
		for (int i = 0; i < 4; i++)
			send_job(rand_bits(8), 1);
		repeat (20) @(posedge clock);
		quiet <= 1'b0;
		cu_configure <= cfg_word;
		random_alfull <= 1'b1;

		for (int i = 0; i < 40; i++) begin
			wait_edge_request();
			repeat (rand_bits(2)) @(posedge clock);
			send_job(rand_bits(8), 1);
		end
		wait_drained(4000);

		// Captured configuration stays in use
		@(posedge clock);
		cu_configure <= '0;
		for (int i = 0; i < 10; i++) begin
			wait_edge_request();
			send_job(rand_bits(8), 1);
		end
		wait_drained(2000);

		// Back-pressure from the host and the arbiter
		random_alfull <= 1'b0;
		force_alfull <= 1'b1;
		hold_grants <= 1'b1;
		for (int i = 0; i < 28; i++)
			send_job(rand_bits(8), 1);
		repeat (30) @(posedge clock);
		@(negedge clock);
		check_value("read_command_bus_request", read_command_bus_request, 0);
		check_value("edge_request", edge_request, 0);
		force_alfull <= 1'b0;
		t = 0;
		@(negedge clock);
		while (!read_command_bus_request) begin
			t++;
			if (t > 50)
				report_error("timeout waiting for read_command_bus_request");
			@(negedge clock);
		end
		repeat (10) @(posedge clock);
		hold_grants <= 1'b0;
		wait_drained(5000);
		repeat (10) @(posedge clock);

		if (issued == expected_total) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("issued %0d commands for %0d jobs", issued, expected_total);
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// Overall run limit
	initial begin
		#2000000;
		$display("simulation ran past its time limit");
		$display("TESTBENCH FAILED");
		$fatal(1, "time limit");
	end

endmodule

`default_nettype wire
